//--- radio_cfg.svh
/*
 * Radio control core configuration
 * Settings-bus register addresses, the radio number reported in
 * readback and the CHDR packet-type codes.
 */
`ifndef RADIO_CFG_SVH
`define RADIO_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// Settings-bus register addresses
////////////////////////////////////////////////////////////////////////////

// Any write here fires a one-cycle DAC sync pulse
`define RADIO_SR_DACSYNC    8'd5
`define RADIO_SR_TEST       8'd7
`define RADIO_SR_MISC_OUTS  8'd24
`define RADIO_SR_READBACK   8'd127
`define RADIO_SR_LEDS       8'd195

// Radio number shown on readback select 2
`define RADIO_NUM           32'd0

////////////////////////////////////////////////////////////////////////////
// CHDR packet types, header bits 63:62
////////////////////////////////////////////////////////////////////////////

`define CHDR_TYPE_DATA      2'd0
`define CHDR_TYPE_FC        2'd1
`define CHDR_TYPE_CMD       2'd2
`define CHDR_TYPE_RESP      2'd3

`endif

//--- chdr_pkg.sv
/*
 * CHDR stream types
 * One 64-bit stream word with its last flag, and the packet types
 * carried in the top two header bits.
 */
`include "radio_cfg.svh"

package chdr_pkg;

   // One stream word, valid and ready travel beside it
   typedef struct packed {
      logic [63:0] data;
      logic        last;
   } chdr_beat_t;

   // Packet type from header bits 63:62
   typedef enum logic [1:0] {
      CHDR_DATA = `CHDR_TYPE_DATA,
      CHDR_FC   = `CHDR_TYPE_FC,
      CHDR_CMD  = `CHDR_TYPE_CMD,
      CHDR_RESP = `CHDR_TYPE_RESP
   } chdr_type_t;

endpackage

//--- radio_regs_pkg.sv
/*
 * Settings bus and readback types
 * A single settings-bus write and the readback selector codes.
 */
package radio_regs_pkg;

   // One settings-bus write, strobe high for a single cycle
   typedef struct packed {
      logic        stb;
      logic [7:0]  addr;
      logic [31:0] data;
   } set_bus_t;

   // Readback selector, unlisted codes read as zero
   typedef enum logic [2:0] {
      RB_TEST_MISC = 3'd0,
      RB_INS_LEDS  = 3'd1,
      RB_RADIO_NUM = 3'd2
   } rb_sel_t;

endpackage

//--- chdr_demux.sv
`timescale 1ns/1ps
/*
 * CHDR packet demux
 * Steers each input packet by its header type: data to the TX port,
 * commands to the control processor, flow control and responses dropped.
 * Routing is combinational, the type is held for the whole packet.
 */
module chdr_demux (
   input  logic                 bus_clk,
   input  logic                 bus_rst,
   input  chdr_pkg::chdr_beat_t i_in,
   input  logic                 i_in_valid,
   output logic                 o_in_ready,
   output chdr_pkg::chdr_beat_t o_tx,
   output logic                 o_tx_valid,
   input  logic                 i_tx_ready,
   output chdr_pkg::chdr_beat_t o_cmd,
   output logic                 o_cmd_valid,
   input  logic                 i_cmd_ready
);

   logic                 first_q;
   chdr_pkg::chdr_type_t dest_q;
   chdr_pkg::chdr_type_t cur_type;
   logic                 route_ready;
   logic                 in_xfer;

   // Header word steers itself, the rest follow the stored type
   assign cur_type = first_q ? chdr_pkg::chdr_type_t'(i_in.data[63:62]) : dest_q;

   assign o_tx        = i_in;
   assign o_tx_valid  = i_in_valid && (cur_type == chdr_pkg::CHDR_DATA);
   assign o_cmd       = i_in;
   assign o_cmd_valid = i_in_valid && (cur_type == chdr_pkg::CHDR_CMD);

   // FC and response packets drain with ready held high
   always_comb begin
      case (cur_type)
         chdr_pkg::CHDR_DATA: route_ready = i_tx_ready;
         chdr_pkg::CHDR_CMD:  route_ready = i_cmd_ready;
         default:             route_ready = 1'b1;
      endcase
   end

   assign o_in_ready = !i_in_valid || route_ready;
   assign in_xfer    = i_in_valid && o_in_ready;

   // Packet boundary tracking
   always_ff @(posedge bus_clk) begin
      if (bus_rst) begin
         first_q <= 1'b1;
         dest_q  <= chdr_pkg::CHDR_DATA;
      end else if (in_xfer) begin
         first_q <= i_in.last;
         if (first_q) begin
            dest_q <= cur_type;
         end
      end
   end

endmodule

//--- radio_ctrl_proc.sv
`timescale 1ns/1ps
/*
 * Radio control processor
 * Turns each command packet into one settings-bus write, then returns
 * a two-word response carrying the readback value sampled with the write.
 * One command is handled at a time.
 */
module radio_ctrl_proc (
   input  logic                     bus_clk,
   input  logic                     bus_rst,
   input  chdr_pkg::chdr_beat_t     i_cmd,
   input  logic                     i_cmd_valid,
   output logic                     o_cmd_ready,
   output radio_regs_pkg::set_bus_t o_set,
   input  logic [63:0]              i_rb_data,
   output chdr_pkg::chdr_beat_t     o_resp,
   output logic                     o_resp_valid,
   input  logic                     i_resp_ready
);

   typedef enum logic [2:0] {
      S_HDR,
      S_PAYLOAD,
      S_DRAIN,
      S_WRITE,
      S_RESP_HDR,
      S_RESP_DATA
   } state_t;

   state_t      state_q;
   logic        cmd_xfer;
   logic        resp_xfer;
   logic [11:0] seq_q;
   logic [31:0] sid_q;
   logic [7:0]  addr_q;
   logic [31:0] data_q;
   logic [63:0] rb_q;
   logic [63:0] resp_hdr;

   assign o_cmd_ready = (state_q == S_HDR) || (state_q == S_PAYLOAD) || (state_q == S_DRAIN);
   assign cmd_xfer    = i_cmd_valid && o_cmd_ready;
   assign resp_xfer   = o_resp_valid && i_resp_ready;

   ////////////////////////////////////////////////////////////////////////////
   // Command FSM
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge bus_clk) begin
      if (bus_rst) begin
         state_q <= S_HDR;
      end else begin
         case (state_q)
            // Header-only packets are dropped here
            S_HDR:       if (cmd_xfer && !i_cmd.last) state_q <= S_PAYLOAD;
            S_PAYLOAD:   if (cmd_xfer) state_q <= i_cmd.last ? S_WRITE : S_DRAIN;
            S_DRAIN:     if (cmd_xfer && i_cmd.last) state_q <= S_WRITE;
            S_WRITE:     state_q <= S_RESP_HDR;
            S_RESP_HDR:  if (resp_xfer) state_q <= S_RESP_DATA;
            S_RESP_DATA: if (resp_xfer) state_q <= S_HDR;
            default:     state_q <= S_HDR;
         endcase
      end
   end

   // Packet fields and readback snapshot
   always_ff @(posedge bus_clk) begin
      if (cmd_xfer && (state_q == S_HDR)) begin
         seq_q <= i_cmd.data[59:48];
         sid_q <= i_cmd.data[31:0];
      end
      if (cmd_xfer && (state_q == S_PAYLOAD)) begin
         addr_q <= i_cmd.data[39:32];
         data_q <= i_cmd.data[31:0];
      end
      // Bank still shows the value from before this write
      if (state_q == S_WRITE) begin
         rb_q <= i_rb_data;
      end
   end

   assign o_set.stb  = (state_q == S_WRITE);
   assign o_set.addr = addr_q;
   assign o_set.data = data_q;

   ////////////////////////////////////////////////////////////////////////////
   // Response words
   ////////////////////////////////////////////////////////////////////////////

   // Stream ID halves swapped so the reply goes back to the sender
   assign resp_hdr = {chdr_pkg::CHDR_RESP, 2'b00, seq_q, 16'd0, sid_q[15:0], sid_q[31:16]};

   assign o_resp_valid = (state_q == S_RESP_HDR) || (state_q == S_RESP_DATA);
   assign o_resp.data  = (state_q == S_RESP_DATA) ? rb_q : resp_hdr;
   assign o_resp.last  = (state_q == S_RESP_DATA);

endmodule

//--- radio_settings.sv
`timescale 1ns/1ps
/*
 * Radio register bank
 * Test, misc-outputs, LED and readback-select registers on the settings
 * bus, the DAC sync pulse, and the 64-bit readback mux.
 */
`include "radio_cfg.svh"

module radio_settings (
   input  logic                     bus_clk,
   input  logic                     bus_rst,
   input  radio_regs_pkg::set_bus_t i_set,
   input  logic [31:0]              i_misc_ins,
   output logic [63:0]              o_rb_data,
   output logic [31:0]              o_misc_outs,
   output logic [2:0]               o_leds,
   output logic                     o_sync_dacs
);

   logic [31:0]             test_q;
   logic [31:0]             misc_q;
   logic [2:0]              leds_q;
   radio_regs_pkg::rb_sel_t rb_sel_q;
   logic                    sync_q;

   ////////////////////////////////////////////////////////////////////////////
   // Address decode
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge bus_clk) begin
      if (bus_rst) begin
         test_q   <= 32'd0;
         misc_q   <= 32'd0;
         leds_q   <= 3'd0;
         rb_sel_q <= radio_regs_pkg::RB_TEST_MISC;
         sync_q   <= 1'b0;
      end else begin
         // Data is ignored, the write itself is the event
         sync_q <= i_set.stb && (i_set.addr == `RADIO_SR_DACSYNC);
         if (i_set.stb) begin
            case (i_set.addr)
               `RADIO_SR_TEST:      test_q   <= i_set.data;
               `RADIO_SR_MISC_OUTS: misc_q   <= i_set.data;
               `RADIO_SR_LEDS:      leds_q   <= i_set.data[2:0];
               `RADIO_SR_READBACK:  rb_sel_q <= radio_regs_pkg::rb_sel_t'(i_set.data[2:0]);
               default:             ;
            endcase
         end
      end
   end

   assign o_misc_outs = misc_q;
   assign o_leds      = leds_q;
   assign o_sync_dacs = sync_q;

   // Readback mux
   always_comb begin
      case (rb_sel_q)
         radio_regs_pkg::RB_TEST_MISC: o_rb_data = {test_q, misc_q};
         radio_regs_pkg::RB_INS_LEDS:  o_rb_data = {i_misc_ins, 29'd0, leds_q};
         radio_regs_pkg::RB_RADIO_NUM: o_rb_data = {32'd0, `RADIO_NUM};
         default:                      o_rb_data = 64'd0;
      endcase
   end

endmodule

//--- radio_core.sv
`timescale 1ns/1ps
/*
 * Radio control core, top level
 * Input packets are split by the demux; commands go through the control
 * processor to the register bank, and responses come back out.
 */
module radio_core (
   input  logic                 bus_clk,
   input  logic                 bus_rst,
   input  chdr_pkg::chdr_beat_t i_in,
   input  logic                 i_in_valid,
   output logic                 o_in_ready,
   output chdr_pkg::chdr_beat_t o_tx,
   output logic                 o_tx_valid,
   input  logic                 i_tx_ready,
   output chdr_pkg::chdr_beat_t o_resp,
   output logic                 o_resp_valid,
   input  logic                 i_resp_ready,
   input  logic [31:0]          i_misc_ins,
   output logic [31:0]          o_misc_outs,
   output logic [2:0]           o_leds,
   output logic                 o_sync_dacs
);

   chdr_pkg::chdr_beat_t     cmd;
   logic                     cmd_valid;
   logic                     cmd_ready;
   radio_regs_pkg::set_bus_t set_bus;
   logic [63:0]              rb_data;

   chdr_demux u_demux (
      .bus_clk(bus_clk), .bus_rst(bus_rst),
      .i_in(i_in), .i_in_valid(i_in_valid), .o_in_ready(o_in_ready),
      .o_tx(o_tx), .o_tx_valid(o_tx_valid), .i_tx_ready(i_tx_ready),
      .o_cmd(cmd), .o_cmd_valid(cmd_valid), .i_cmd_ready(cmd_ready));

   radio_ctrl_proc u_ctrl (
      .bus_clk(bus_clk), .bus_rst(bus_rst),
      .i_cmd(cmd), .i_cmd_valid(cmd_valid), .o_cmd_ready(cmd_ready),
      .o_set(set_bus), .i_rb_data(rb_data),
      .o_resp(o_resp), .o_resp_valid(o_resp_valid), .i_resp_ready(i_resp_ready));

   radio_settings u_settings (
      .bus_clk(bus_clk), .bus_rst(bus_rst),
      .i_set(set_bus), .i_misc_ins(i_misc_ins), .o_rb_data(rb_data),
      .o_misc_outs(o_misc_outs), .o_leds(o_leds), .o_sync_dacs(o_sync_dacs));

endmodule

//--- tb_radio_core.sv
`timescale 1ns/1ps
/*
 * Testbench for the radio control core
 * Random data, command and discard packets under random back-pressure,
 * checked against queues of expected TX and response words and shadow
 * copies of the register bank.
 */
`include "radio_cfg.svh"

module tb_radio_core;

   localparam int          TIMEOUT = 2000;
   localparam logic [31:0] SEED    = 32'haa71a170;

   logic                 bus_clk;
   logic                 bus_rst;
   chdr_pkg::chdr_beat_t i_in;
   logic                 i_in_valid;
   logic                 o_in_ready;
   chdr_pkg::chdr_beat_t o_tx;
   logic                 o_tx_valid;
   logic                 i_tx_ready;
   chdr_pkg::chdr_beat_t o_resp;
   logic                 o_resp_valid;
   logic                 i_resp_ready;
   logic [31:0]          i_misc_ins;
   logic [31:0]          o_misc_outs;
   logic [2:0]           o_leds;
   logic                 o_sync_dacs;

   integer      seed;
   integer      rdy_seed;
   logic        rdy_random;
   logic        timed_out;
   int          err_count;
   int          test_count;
   int          fail_count;
   int          test_err_start;
   int          sync_count;
   int          exp_sync;
   logic [64:0] exp_tx[$];
   logic [64:0] exp_resp[$];
   logic [64:0] exp_word;
   // Shadow copies of the register bank
   logic [31:0] sh_test;
   logic [31:0] sh_misc;
   logic [2:0]  sh_leds;
   logic [2:0]  sh_sel;

   radio_core u_dut (.*);

   initial begin
      bus_clk = 1'b0;
      forever #5 bus_clk = ~bus_clk;
   end

   // Random back-pressure on both output streams
   initial begin
      logic [31:0] r;
      rdy_seed     = SEED;
      i_tx_ready   = 1'b1;
      i_resp_ready = 1'b1;
      forever begin
         @(negedge bus_clk);
         r = $random(rdy_seed);
         i_tx_ready   = !rdy_random || (r[1:0] != 2'b00);
         i_resp_ready = !rdy_random || (r[3:2] != 2'b00);
      end
   end

   function automatic logic [31:0] next_rand();
      next_rand = $random(seed);
   endfunction

   function automatic logic [63:0] rand64();
      rand64 = {next_rand(), next_rand()};
   endfunction

   task automatic check_val(input string name, input logic [63:0] got,
                            input logic [63:0] exp);
      if (got !== exp) begin
         $display("ERR %s: got %h, expected %h", name, got, exp);
         err_count = err_count + 1;
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////////////////////////////////////////

   function automatic logic [63:0] read_model();
      case (sh_sel)
         3'd0:    read_model = {sh_test, sh_misc};
         3'd1:    read_model = {i_misc_ins, 29'd0, sh_leds};
         3'd2:    read_model = {32'd0, `RADIO_NUM};
         default: read_model = 64'd0;
      endcase
   endfunction

   task automatic write_model(input logic [7:0] addr, input logic [31:0] data);
      case (addr)
         `RADIO_SR_TEST:      sh_test = data;
         `RADIO_SR_MISC_OUTS: sh_misc = data;
         `RADIO_SR_LEDS:      sh_leds = data[2:0];
         `RADIO_SR_READBACK:  sh_sel = data[2:0];
         `RADIO_SR_DACSYNC:   exp_sync = exp_sync + 1;
         default:             ;
      endcase
   endtask

   function automatic logic [7:0] pick_addr(input logic [1:0] k);
      case (k)
         2'd0:    pick_addr = `RADIO_SR_TEST;
         2'd1:    pick_addr = `RADIO_SR_MISC_OUTS;
         2'd2:    pick_addr = `RADIO_SR_LEDS;
         default: pick_addr = `RADIO_SR_READBACK;
      endcase
   endfunction

   // Output monitor samples each transfer at the rising edge
   always @(posedge bus_clk) begin
      if (!bus_rst) begin
         if (o_tx_valid && i_tx_ready) begin
            if (exp_tx.size() == 0) begin
               $display("Unexpected word on the TX output: %h", o_tx.data);
               err_count = err_count + 1;
            end else begin
               exp_word = exp_tx.pop_front();
               check_val("o_tx.data", o_tx.data, exp_word[64:1]);
               check_val("o_tx.last", 64'(o_tx.last), 64'(exp_word[0]));
            end
         end
         if (o_resp_valid && i_resp_ready) begin
            if (exp_resp.size() == 0) begin
               $display("Unexpected word on the response output: %h", o_resp.data);
               err_count = err_count + 1;
            end else begin
               exp_word = exp_resp.pop_front();
               check_val("o_resp.data", o_resp.data, exp_word[64:1]);
               check_val("o_resp.last", 64'(o_resp.last), 64'(exp_word[0]));
            end
         end
         if (o_sync_dacs) sync_count = sync_count + 1;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////////////////////

   task automatic drive_word(input logic [63:0] data, input logic last);
      int          t;
      logic [31:0] r;
      if (timed_out) return;
      i_in.data  = data;
      i_in.last  = last;
      i_in_valid = 1'b1;
      t = 0;
      @(posedge bus_clk);
      while (!o_in_ready && t < TIMEOUT) begin
         t = t + 1;
         @(posedge bus_clk);
      end
      if (!o_in_ready) begin
         $display("Timeout: the input stream never became ready");
         err_count = err_count + 1;
         timed_out = 1'b1;
      end
      @(negedge bus_clk);
      i_in_valid = 1'b0;
      r = next_rand();
      if (r[1:0] == 2'b00) @(negedge bus_clk);
   endtask

   // Only data packets reach an output; a one-word command is header-only
   task automatic send_packet(input logic [1:0] ptype, input int len);
      logic [63:0] w;
      for (int i = 0; i < len; i++) begin
         w = rand64();
         if (i == 0) w[63:62] = ptype;
         if (ptype == `CHDR_TYPE_DATA) exp_tx.push_back({w, i == len - 1});
         drive_word(w, i == len - 1);
      end
   endtask

   task automatic send_cmd(input logic [7:0] addr, input logic [31:0] data, input int extra);
      logic [63:0] hdr;
      logic [63:0] pay;
      hdr = rand64();
      hdr[63:62] = `CHDR_TYPE_CMD;
      pay = rand64();
      pay[39:0] = {addr, data};
      exp_resp.push_back({`CHDR_TYPE_RESP, 2'b00, hdr[59:48], 16'h0000,
                          hdr[15:0], hdr[31:16], 1'b0});
      exp_resp.push_back({read_model(), 1'b1});
      write_model(addr, data);
      drive_word(hdr, 1'b0);
      drive_word(pay, extra == 0);
      for (int i = 0; i < extra; i++) begin
         drive_word(rand64(), i == extra - 1);
      end
   endtask

   task automatic finish_test(input string name);
      int t;
      t = 0;
      while ((exp_tx.size() != 0 || exp_resp.size() != 0) && t < TIMEOUT && !timed_out) begin
         t = t + 1;
         @(negedge bus_clk);
      end
      if (exp_tx.size() != 0 || exp_resp.size() != 0) begin
         $display("Timeout: expected output words never arrived in %s", name);
         err_count = err_count + 1;
         timed_out = 1'b1;
      end
      // Let the last write and sync pulse settle
      repeat (4) @(negedge bus_clk);
      check_val("o_misc_outs", 64'(o_misc_outs), 64'(sh_misc));
      check_val("o_leds", 64'(o_leds), 64'(sh_leds));
      check_val("o_sync_dacs pulses", 64'(sync_count), 64'(exp_sync));
      test_count = test_count + 1;
      if (err_count == test_err_start) begin
         $display("test %s: ok", name);
      end else begin
         fail_count = fail_count + 1;
         $display("test %s: FAILED with %0d errors", name, err_count - test_err_start);
      end
      test_err_start = err_count;
      i_misc_ins = next_rand();
   endtask

   initial begin : main
      logic [31:0] r;
      seed = SEED;
      rdy_random = 1'b0;
      timed_out = 1'b0;
      err_count = 0;
      test_count = 0;
      fail_count = 0;
      test_err_start = 0;
      sync_count = 0;
      exp_sync = 0;
      sh_test = 32'd0;
      sh_misc = 32'd0;
      sh_leds = 3'd0;
      sh_sel = 3'd0;
      i_in = '0;
      i_in_valid = 1'b0;
      i_misc_ins = 32'd0;
      bus_rst = 1'b1;
      repeat (8) @(posedge bus_clk);
      @(negedge bus_clk);
      bus_rst = 1'b0;

      check_val("o_in_ready", 64'(o_in_ready), 64'd1);
      check_val("o_tx_valid", 64'(o_tx_valid), 64'd0);
      check_val("o_resp_valid", 64'(o_resp_valid), 64'd0);
      check_val("o_sync_dacs", 64'(o_sync_dacs), 64'd0);
      finish_test("reset_state");

      rdy_random = 1'b1;
      repeat (20) begin
         r = next_rand();
         send_packet(`CHDR_TYPE_DATA, int'(r[2:0]) + 1);
      end
      finish_test("data_pass");

      repeat (30) begin
         r = next_rand();
         send_cmd(pick_addr(r[1:0]), next_rand(), 0);
      end
      finish_test("register_writes");

      // Each select followed by a command that carries its readback value
      for (int s = 0; s < 8; s++) begin
         r = next_rand();
         send_cmd(`RADIO_SR_READBACK, {r[31:3], 3'(s)}, 0);
         send_cmd(`RADIO_SR_TEST, next_rand(), 0);
      end
      finish_test("readback_map");

      repeat (20) begin
         r = next_rand();
         if (r[0]) send_cmd(`RADIO_SR_DACSYNC, next_rand(), 0);
         else send_cmd(pick_addr(r[2:1]), next_rand(), 0);
      end
      finish_test("dac_sync");

      repeat (40) begin
         r = next_rand();
         case (r[2:0])
            3'd0:    send_packet(`CHDR_TYPE_DATA, int'(r[5:4]) + 1);
            3'd1:    send_packet(`CHDR_TYPE_FC, int'(r[5:4]) + 1);
            3'd2:    send_packet(`CHDR_TYPE_RESP, int'(r[5:4]) + 1);
            3'd3:    send_packet(`CHDR_TYPE_CMD, 1);
            3'd4:    send_cmd(pick_addr(r[7:6]), next_rand(), int'(r[5:4]) + 1);
            default: send_cmd(pick_addr(r[7:6]), next_rand(), 0);
         endcase
      end
      finish_test("discards_malformed");

      $display("Summary: %0d tests, %0d failed, %0d errors", test_count, fail_count, err_count);
      if (err_count == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

//--- radio_ctrl.f
+incdir+.
chdr_pkg.sv
radio_regs_pkg.sv
chdr_demux.sv
radio_ctrl_proc.sv
radio_settings.sv
radio_core.sv
tb_radio_core.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the radio control core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_radio_core -Mdir obj_dir -f radio_ctrl.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/Vtb_radio_core)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -q "^All tests passed$"; then
   exit 0
fi
exit 1
